//--- logic/decode_pkg.sv
`default_nettype none

package decode_pkg;

  // datapath and field widths
  localparam int XLEN      = 32;
  localparam int REG_IDX_W = 5;
  localparam int ALU_OP_W  = 4;

  typedef logic [XLEN-1:0]      word_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  // one instruction word, raw or split into R-type fields
  typedef union packed {
    word_t raw;
    struct packed {
      logic [6:0] funct7;
      reg_idx_t   rs2;
      reg_idx_t   rs1;
      logic [2:0] funct3;
      reg_idx_t   rd;
      logic [6:0] opcode;
    } f;
  } instr_word_u;

  // base opcodes
  localparam logic [6:0] OPC_OP       = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
  localparam logic [6:0] OPC_LOAD     = 7'b0000011;
  localparam logic [6:0] OPC_STORE    = 7'b0100011;
  localparam logic [6:0] OPC_LUI      = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
  localparam logic [6:0] OPC_JAL      = 7'b1101111;
  localparam logic [6:0] OPC_JALR     = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
  localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;

  // functional unit source A
  localparam logic [1:0] SRC_A_RS1  = 2'd0;
  localparam logic [1:0] SRC_A_PC   = 2'd1;
  localparam logic [1:0] SRC_A_ZERO = 2'd2;

  // functional unit source B
  localparam logic [2:0] SRC_B_RS2   = 3'd0;
  localparam logic [2:0] SRC_B_IMM_I = 3'd1;
  localparam logic [2:0] SRC_B_SHAMT = 3'd2;
  localparam logic [2:0] SRC_B_IMM_S = 3'd3;
  localparam logic [2:0] SRC_B_IMM_U = 3'd4;

  // register write data produced in decode
  localparam logic [1:0] WSRC_NONE  = 2'd0;
  localparam logic [1:0] WSRC_PC4   = 2'd1;
  localparam logic [1:0] WSRC_IMM_U = 2'd2;

  localparam logic [ALU_OP_W-1:0] ALU_ADD = '0;

endpackage

`default_nettype wire

//--- logic/instr_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module instr_decoder (
  input  decode_pkg::instr_word_u       instr,
  output logic [1:0]                    src_a_sel,
  output logic [2:0]                    src_b_sel,
  output logic [1:0]                    w_src,
  output logic [decode_pkg::ALU_OP_W-1:0] alu_op,
  output logic                          wen,
  output logic                          jump,
  output logic                          j_sel,
  output logic                          branch,
  output logic                          load,
  output logic                          store,
  output logic                          ifence,
  output logic                          illegal
);

  always_comb begin
    // defaults describe a no-op
    src_a_sel = decode_pkg::SRC_A_RS1;
    src_b_sel = decode_pkg::SRC_B_RS2;
    w_src     = decode_pkg::WSRC_NONE;
    alu_op    = decode_pkg::ALU_ADD;
    wen       = 1'b0;
    jump      = 1'b0;
    j_sel     = 1'b0;
    branch    = 1'b0;
    load      = 1'b0;
    store     = 1'b0;
    ifence    = 1'b0;
    illegal   = 1'b0;

    case (instr.f.opcode)
      decode_pkg::OPC_OP: begin
        alu_op = {instr.f.funct7[5], instr.f.funct3};
        wen    = 1'b1;
      end
      decode_pkg::OPC_OP_IMM: begin
        // slli, srli and srai take shamt from the rs2 field
        if (instr.f.funct3 == 3'd1 || instr.f.funct3 == 3'd5)
          src_b_sel = decode_pkg::SRC_B_SHAMT;
        else
          src_b_sel = decode_pkg::SRC_B_IMM_I;
        alu_op = {(instr.f.funct3 == 3'd5) & instr.f.funct7[5], instr.f.funct3};
        wen    = 1'b1;
      end
      decode_pkg::OPC_LOAD: begin
        src_b_sel = decode_pkg::SRC_B_IMM_I;
        load      = 1'b1;
        wen       = 1'b1;
      end
      decode_pkg::OPC_STORE: begin
        src_b_sel = decode_pkg::SRC_B_IMM_S;
        store     = 1'b1;
      end
      decode_pkg::OPC_LUI: begin
        src_a_sel = decode_pkg::SRC_A_ZERO;
        src_b_sel = decode_pkg::SRC_B_IMM_U;
        w_src     = decode_pkg::WSRC_IMM_U;
        wen       = 1'b1;
      end
      decode_pkg::OPC_AUIPC: begin
        src_a_sel = decode_pkg::SRC_A_PC;
        src_b_sel = decode_pkg::SRC_B_IMM_U;
        wen       = 1'b1;
      end
      decode_pkg::OPC_JAL: begin
        jump  = 1'b1;
        j_sel = 1'b1;
        w_src = decode_pkg::WSRC_PC4;
        wen   = 1'b1;
      end
      decode_pkg::OPC_JALR: begin
        jump  = 1'b1;
        w_src = decode_pkg::WSRC_PC4;
        wen   = 1'b1;
      end
      decode_pkg::OPC_BRANCH: begin
        branch = 1'b1;
      end
      decode_pkg::OPC_MISC_MEM: begin
        // plain fence needs nothing in order
        ifence = (instr.f.funct3 == 3'd1);
      end
      default: begin
        illegal = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- logic/imm_gen.sv
`timescale 1ns/100ps
`default_nettype none

module imm_gen (
  input  decode_pkg::instr_word_u instr,
  output decode_pkg::word_t       imm_i,
  output decode_pkg::word_t       imm_s,
  output decode_pkg::word_t       imm_b,
  output decode_pkg::word_t       imm_u,
  output decode_pkg::word_t       imm_j,
  output decode_pkg::word_t       shamt
);

  decode_pkg::word_t w;

  assign w = instr.raw;

  assign imm_i = {{20{w[31]}}, w[31:20]};
  assign imm_s = {{20{w[31]}}, w[31:25], w[11:7]};

  // branch and jump offsets are in half-words
  assign imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
  assign imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};

  assign imm_u = {w[31:12], 12'b0};

  // shift amount sits in the rs2 slot
  assign shamt = {{(decode_pkg::XLEN - decode_pkg::REG_IDX_W){1'b0}}, instr.f.rs2};

endmodule

`default_nettype wire

//--- logic/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file (
  input  logic                 CLK,
  input  logic                 nRST,
  input  decode_pkg::reg_idx_t rs1,
  input  decode_pkg::reg_idx_t rs2,
  output decode_pkg::word_t    rs1_data,
  output decode_pkg::word_t    rs2_data,
  input  logic                 wb_en,
  input  decode_pkg::reg_idx_t wb_rd,
  input  decode_pkg::word_t    wb_data
);

  decode_pkg::word_t regs [2**decode_pkg::REG_IDX_W];

  // x0 is cleared by reset and never written
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < 2**decode_pkg::REG_IDX_W; i++)
        regs[i] <= '0;
    end else if (wb_en && wb_rd != '0) begin
      regs[wb_rd] <= wb_data;
    end
  end

  // no write bypass, reads see the old contents
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  assert property (@(posedge CLK) disable iff (!nRST)
    (rs1 == '0) |-> (rs1_data == '0));

  assert property (@(posedge CLK) disable iff (!nRST)
    (rs2 == '0) |-> (rs2_data == '0));

endmodule

`default_nettype wire

//--- logic/operand_select.sv
`timescale 1ns/100ps
`default_nettype none

module operand_select (
  input  logic [1:0]        src_a_sel,
  input  logic [2:0]        src_b_sel,
  input  logic [1:0]        w_src,
  input  logic              j_sel,
  input  decode_pkg::word_t rs1_data,
  input  decode_pkg::word_t rs2_data,
  input  decode_pkg::word_t pc,
  input  decode_pkg::word_t imm_i,
  input  decode_pkg::word_t imm_s,
  input  decode_pkg::word_t imm_u,
  input  decode_pkg::word_t imm_j,
  input  decode_pkg::word_t shamt,
  output decode_pkg::word_t port_a,
  output decode_pkg::word_t port_b,
  output decode_pkg::word_t j_base,
  output decode_pkg::word_t j_offset,
  output decode_pkg::word_t wdata
);

  always_comb begin
    case (src_a_sel)
      decode_pkg::SRC_A_RS1: port_a = rs1_data;
      decode_pkg::SRC_A_PC:  port_a = pc;
      default:               port_a = '0;
    endcase
  end

  always_comb begin
    case (src_b_sel)
      decode_pkg::SRC_B_RS2:   port_b = rs2_data;
      decode_pkg::SRC_B_IMM_I: port_b = imm_i;
      decode_pkg::SRC_B_SHAMT: port_b = shamt;
      decode_pkg::SRC_B_IMM_S: port_b = imm_s;
      decode_pkg::SRC_B_IMM_U: port_b = imm_u;
      default:                 port_b = '0;
    endcase
  end

  // jal is pc relative, jalr is rs1 relative
  assign j_base   = j_sel ? pc : rs1_data;
  assign j_offset = j_sel ? imm_j : imm_i;

  always_comb begin
    case (w_src)
      decode_pkg::WSRC_PC4:   wdata = pc + 32'd4;
      decode_pkg::WSRC_IMM_U: wdata = imm_u;
      default:                wdata = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/fence_tracker.sv
`timescale 1ns/100ps
`default_nettype none

module fence_tracker (
  input  logic CLK,
  input  logic nRST,
  input  logic fence_accept,
  input  logic iflush_done,
  input  logic dflush_done,
  output logic icache_flush,
  output logic dcache_flush,
  output logic fence_busy
);

  logic iflushed;
  logic dflushed;

  // one request per accepted fence.i
  assign icache_flush = fence_accept;
  assign dcache_flush = fence_accept;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST)
      iflushed <= 1'b1;
    else if (fence_accept)
      iflushed <= 1'b0;
    else if (iflush_done)
      iflushed <= 1'b1;
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST)
      dflushed <= 1'b1;
    else if (fence_accept)
      dflushed <= 1'b0;
    else if (dflush_done)
      dflushed <= 1'b1;
  end

  assign fence_busy = !iflushed || !dflushed;

  // decode_ready must hold fetch off until both caches are done
  assert property (@(posedge CLK) disable iff (!nRST)
    fence_busy |-> !fence_accept);

endmodule

`default_nettype wire

//--- logic/decode_execute_latch.sv
`timescale 1ns/100ps
`default_nettype none

module decode_execute_latch (
  input  logic                            CLK,
  input  logic                            nRST,
  input  logic                            flush,
  input  logic                            stall_ex,
  input  logic                            accept,
  input  decode_pkg::word_t               pc, port_a, port_b, imm_b,
  input  decode_pkg::word_t               j_base, j_offset, wdata, store_data,
  input  logic [decode_pkg::ALU_OP_W-1:0] alu_op,
  input  decode_pkg::reg_idx_t            rd,
  input  logic                            wen, jump, branch,
  input  logic [2:0]                      branch_type,
  input  logic                            load, store, illegal,
  output decode_pkg::word_t               ex_pc, ex_pc4, ex_port_a, ex_port_b, ex_imm_b,
  output decode_pkg::word_t               ex_j_base, ex_j_offset, ex_wdata, ex_store_data,
  output logic [decode_pkg::ALU_OP_W-1:0] ex_alu_op,
  output decode_pkg::reg_idx_t            ex_rd,
  output logic                            ex_wen, ex_jump, ex_branch,
  output logic [2:0]                      ex_branch_type,
  output logic                            ex_load, ex_store, ex_illegal,
  output logic                            ex_valid
);

  logic update;
  logic keep;

  // flush wins over stall, otherwise a free latch takes a bubble or the new word
  assign update = flush || !stall_ex;
  assign keep   = !flush && accept;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ex_pc          <= '0;
      ex_pc4         <= '0;
      ex_port_a      <= '0;
      ex_port_b      <= '0;
      ex_imm_b       <= '0;
      ex_j_base      <= '0;
      ex_j_offset    <= '0;
      ex_wdata       <= '0;
      ex_store_data  <= '0;
      ex_alu_op      <= '0;
      ex_rd          <= '0;
      ex_wen         <= 1'b0;
      ex_jump        <= 1'b0;
      ex_branch      <= 1'b0;
      ex_branch_type <= '0;
      ex_load        <= 1'b0;
      ex_store       <= 1'b0;
      ex_illegal     <= 1'b0;
      ex_valid       <= 1'b0;
    end else if (update) begin
      ex_pc          <= keep ? pc : '0;
      ex_pc4         <= keep ? pc + 32'd4 : '0;
      ex_port_a      <= keep ? port_a : '0;
      ex_port_b      <= keep ? port_b : '0;
      ex_imm_b       <= keep ? imm_b : '0;
      ex_j_base      <= keep ? j_base : '0;
      ex_j_offset    <= keep ? j_offset : '0;
      ex_wdata       <= keep ? wdata : '0;
      ex_store_data  <= keep ? store_data : '0;
      ex_alu_op      <= keep ? alu_op : '0;
      ex_rd          <= keep ? rd : '0;
      ex_wen         <= keep && wen;
      ex_jump        <= keep && jump;
      ex_branch      <= keep && branch;
      ex_branch_type <= keep ? branch_type : '0;
      ex_load        <= keep && load;
      ex_store       <= keep && store;
      ex_illegal     <= keep && illegal;
      ex_valid       <= keep;
    end
  end

  // execute sees a frozen instruction for as long as it stalls
  assert property (@(posedge CLK) disable iff (!nRST)
    (stall_ex && !flush) |=> $stable({ex_pc, ex_pc4, ex_port_a, ex_port_b, ex_imm_b,
                                      ex_j_base, ex_j_offset, ex_wdata, ex_store_data,
                                      ex_alu_op, ex_rd, ex_wen, ex_jump, ex_branch,
                                      ex_branch_type, ex_load, ex_store, ex_illegal,
                                      ex_valid}));

endmodule

`default_nettype wire

//--- logic/rv_decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

module rv_decode_stage (
  input  logic                            CLK,
  input  logic                            nRST,
  input  decode_pkg::instr_word_u         instr,
  input  decode_pkg::word_t               pc,
  input  logic                            instr_valid,
  input  logic                            stall_ex,
  input  logic                            flush,
  input  logic                            wb_en,
  input  decode_pkg::reg_idx_t            wb_rd,
  input  decode_pkg::word_t               wb_data,
  input  logic                            iflush_done,
  input  logic                            dflush_done,
  output logic                            decode_ready,
  output logic                            icache_flush,
  output logic                            dcache_flush,
  output decode_pkg::word_t               ex_pc, ex_pc4, ex_port_a, ex_port_b, ex_imm_b,
  output decode_pkg::word_t               ex_j_base, ex_j_offset, ex_wdata, ex_store_data,
  output logic [decode_pkg::ALU_OP_W-1:0] ex_alu_op,
  output decode_pkg::reg_idx_t            ex_rd,
  output logic                            ex_wen, ex_jump, ex_branch,
  output logic [2:0]                      ex_branch_type,
  output logic                            ex_load, ex_store, ex_illegal,
  output logic                            ex_valid
);

  // decoder controls
  logic [1:0]                      src_a_sel;
  logic [2:0]                      src_b_sel;
  logic [1:0]                      w_src;
  logic [decode_pkg::ALU_OP_W-1:0] alu_op;
  logic                            wen, jump, j_sel, branch, load, store, ifence, illegal;

  // immediates and register operands
  decode_pkg::word_t    imm_i, imm_s, imm_b, imm_u, imm_j, shamt;
  decode_pkg::reg_idx_t rs1, rs2, rd;
  decode_pkg::word_t    rs1_data, rs2_data;

  // selected operands
  decode_pkg::word_t port_a, port_b, j_base, j_offset, wdata, store_data;
  logic [2:0]        branch_type;

  logic accept;
  logic fence_accept;
  logic fence_busy;

  assign rs1         = instr.f.rs1;
  assign rs2         = instr.f.rs2;
  assign rd          = instr.f.rd;
  assign branch_type = instr.f.funct3;
  assign store_data  = rs2_data;

  // handshake with fetch
  assign decode_ready = !stall_ex && !fence_busy;
  assign accept       = instr_valid && decode_ready;
  assign fence_accept = accept && ifence;

  instr_decoder u_decoder (.*);

  imm_gen u_imm_gen (.*);

  reg_file u_reg_file (.*);

  operand_select u_operand_select (.*);

  fence_tracker u_fence_tracker (.*);

  decode_execute_latch u_de_latch (.*);

endmodule

`default_nettype wire

//--- test/decode_tb.sv
`timescale 1ns/100ps
`default_nettype none

module decode_tb;

  localparam int CLK_PERIOD      = 100;
  localparam int RESET_CYCLES    = 16;
  localparam int TEST_CYCLES     = 3800;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + TEST_CYCLES + 184;

  logic                    CLK;
  logic                    nRST;
  decode_pkg::instr_word_u instr;
  decode_pkg::word_t       pc;
  logic                    instr_valid, stall_ex, flush, wb_en;
  decode_pkg::reg_idx_t    wb_rd;
  decode_pkg::word_t       wb_data;
  logic                    iflush_done, dflush_done;
  logic                    decode_ready, icache_flush, dcache_flush;
  decode_pkg::word_t       ex_pc, ex_pc4, ex_port_a, ex_port_b, ex_imm_b;
  decode_pkg::word_t       ex_j_base, ex_j_offset, ex_wdata, ex_store_data;
  logic [3:0]              ex_alu_op;
  decode_pkg::reg_idx_t    ex_rd;
  logic                    ex_wen, ex_jump, ex_branch;
  logic [2:0]              ex_branch_type;
  logic                    ex_load, ex_store, ex_illegal, ex_valid;

  integer      seed;
  integer      errors;
  integer      checks;
  logic [31:0] mregs [32];
  logic        iflushed_m, dflushed_m;
  int          icount, dcount;
  logic        hold_instr;

  // expected latch contents after the next edge
  logic [31:0] e_pc, e_pc4, e_a, e_b, e_immb, e_jb, e_jo, e_wd, e_sd;
  logic [3:0]  e_alu;
  logic [4:0]  e_rd;
  logic [2:0]  e_bt;
  logic        e_wen, e_jmp, e_br, e_ld, e_st, e_ill, e_valid;

  rv_decode_stage dut0 (.*);

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  task automatic next_rand(output logic [31:0] r);
    r = $random(seed);
  endtask

  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic clear_expected();
    {e_pc, e_pc4, e_a, e_b, e_immb, e_jb, e_jo, e_wd, e_sd} = '0;
    {e_alu, e_rd, e_bt} = '0;
    {e_wen, e_jmp, e_br, e_ld, e_st, e_ill, e_valid} = '0;
  endtask

  // random word with an opcode from one of the classes, or an unknown one
  task automatic make_instr(output logic [31:0] w);
    logic [31:0] k;
    next_rand(w);
    next_rand(k);
    case (k % 12)
      0: w[6:0] = decode_pkg::OPC_OP;
      1: w[6:0] = decode_pkg::OPC_OP_IMM;
      2: w[6:0] = decode_pkg::OPC_LOAD;
      3: w[6:0] = decode_pkg::OPC_STORE;
      4: w[6:0] = decode_pkg::OPC_LUI;
      5: w[6:0] = decode_pkg::OPC_AUIPC;
      6: w[6:0] = decode_pkg::OPC_JAL;
      7: w[6:0] = decode_pkg::OPC_JALR;
      8: w[6:0] = decode_pkg::OPC_BRANCH;
      9: begin
        // fence or fence.i
        w[6:0]   = decode_pkg::OPC_MISC_MEM;
        w[14:12] = {2'b00, k[4]};
      end
      default: begin
        case (k[5:4])
          2'd0: w[6:0] = 7'b1110011;
          2'd1: w[6:0] = 7'b0101111;
          2'd2: w[6:0] = 7'b1010011;
          default: w[6:0] = 7'b0000000;
        endcase
      end
    endcase
  endtask

  task automatic drive_inputs();
    logic [31:0] r;
    logic [31:0] w;
    next_rand(r);
    stall_ex = (r[2:0] == 3'd0);
    flush    = (r[7:4] == 4'd0);
    wb_en    = r[8];
    wb_rd    = r[13:9];
    next_rand(r);
    wb_data = r;
    // cache done pulses count down from each request
    iflush_done = 1'b0;
    if (icount > 0) begin
      icount--;
      iflush_done = (icount == 0);
    end
    dflush_done = 1'b0;
    if (dcount > 0) begin
      dcount--;
      dflush_done = (dcount == 0);
    end
    // fetch keeps an unaccepted instruction in place
    if (!hold_instr) begin
      next_rand(r);
      instr_valid = r[0] | r[1];
      next_rand(r);
      pc = {r[31:2], 2'b00};
      make_instr(w);
      instr.raw = w;
    end
  endtask

  task automatic predict_latch(input logic accept_m);
    logic [31:0] w, rs1v, rs2v, imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [31:0] a, b, wd;
    logic [3:0]  alu;
    logic [2:0]  f3;
    logic        wen_m, jmp, jsel, br, ld, st, ill;
    w     = instr.raw;
    f3    = w[14:12];
    rs1v  = mregs[w[19:15]];
    rs2v  = mregs[w[24:20]];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
    imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    imm_u = {w[31:12], 12'h000};
    imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    a     = rs1v;
    b     = rs2v;
    wd    = '0;
    alu   = '0;
    {wen_m, jmp, jsel, br, ld, st, ill} = '0;
    case (w[6:0])
      decode_pkg::OPC_OP: begin
        alu   = {w[30], f3};
        wen_m = 1'b1;
      end
      decode_pkg::OPC_OP_IMM: begin
        b     = (f3 == 3'd1 || f3 == 3'd5) ? {27'd0, w[24:20]} : imm_i;
        alu   = {(f3 == 3'd5) && w[30], f3};
        wen_m = 1'b1;
      end
      decode_pkg::OPC_LOAD: begin
        b     = imm_i;
        ld    = 1'b1;
        wen_m = 1'b1;
      end
      decode_pkg::OPC_STORE: begin
        b  = imm_s;
        st = 1'b1;
      end
      decode_pkg::OPC_LUI: begin
        a     = '0;
        b     = imm_u;
        wd    = imm_u;
        wen_m = 1'b1;
      end
      decode_pkg::OPC_AUIPC: begin
        a     = pc;
        b     = imm_u;
        wen_m = 1'b1;
      end
      decode_pkg::OPC_JAL: begin
        jmp   = 1'b1;
        jsel  = 1'b1;
        wd    = pc + 32'd4;
        wen_m = 1'b1;
      end
      decode_pkg::OPC_JALR: begin
        jmp   = 1'b1;
        wd    = pc + 32'd4;
        wen_m = 1'b1;
      end
      decode_pkg::OPC_BRANCH: br = 1'b1;
      decode_pkg::OPC_MISC_MEM: ill = 1'b0;
      default: ill = 1'b1;
    endcase
    // flush first, then hold under stall, then bubble or load
    if (flush) begin
      clear_expected();
    end else if (!stall_ex) begin
      if (!accept_m) begin
        clear_expected();
      end else begin
        {e_pc, e_pc4, e_a, e_b, e_immb} = {pc, pc + 32'd4, a, b, imm_b};
        e_jb    = jsel ? pc : rs1v;
        e_jo    = jsel ? imm_j : imm_i;
        e_wd    = wd;
        e_sd    = rs2v;
        e_alu   = alu;
        e_rd    = w[11:7];
        e_bt    = f3;
        {e_wen, e_jmp, e_br, e_ld, e_st, e_ill} = {wen_m, jmp, br, ld, st, ill};
        e_valid = 1'b1;
      end
    end
  endtask

  task automatic step_model();
    logic        busy;
    logic        accept_m;
    logic        fence_m;
    logic [31:0] r;
    busy     = !iflushed_m || !dflushed_m;
    accept_m = instr_valid && !stall_ex && !busy;
    fence_m  = accept_m && instr.raw[6:0] == decode_pkg::OPC_MISC_MEM
               && instr.raw[14:12] == 3'd1;
    compare_field("decode_ready", {31'd0, decode_ready}, {31'd0, !stall_ex && !busy});
    compare_field("icache_flush", {31'd0, icache_flush}, {31'd0, fence_m});
    compare_field("dcache_flush", {31'd0, dcache_flush}, {31'd0, fence_m});
    predict_latch(accept_m);
    // writeback lands at the coming edge, after the reads above
    if (wb_en && wb_rd != 5'd0)
      mregs[wb_rd] = wb_data;
    if (fence_m) begin
      iflushed_m = 1'b0;
      dflushed_m = 1'b0;
      next_rand(r);
      icount = 1 + int'(r[2:0]);
      dcount = 1 + int'(r[5:3]);
    end else begin
      if (iflush_done)
        iflushed_m = 1'b1;
      if (dflush_done)
        dflushed_m = 1'b1;
    end
    hold_instr = instr_valid && !accept_m;
  endtask

  task automatic check_outputs();
    compare_field("ex_pc", ex_pc, e_pc);
    compare_field("ex_pc4", ex_pc4, e_pc4);
    compare_field("ex_port_a", ex_port_a, e_a);
    compare_field("ex_port_b", ex_port_b, e_b);
    compare_field("ex_imm_b", ex_imm_b, e_immb);
    compare_field("ex_j_base", ex_j_base, e_jb);
    compare_field("ex_j_offset", ex_j_offset, e_jo);
    compare_field("ex_wdata", ex_wdata, e_wd);
    compare_field("ex_store_data", ex_store_data, e_sd);
    compare_field("ex_alu_op", {28'd0, ex_alu_op}, {28'd0, e_alu});
    compare_field("ex_rd", {27'd0, ex_rd}, {27'd0, e_rd});
    compare_field("ex_branch_type", {29'd0, ex_branch_type}, {29'd0, e_bt});
    compare_field("ex_wen", {31'd0, ex_wen}, {31'd0, e_wen});
    compare_field("ex_jump", {31'd0, ex_jump}, {31'd0, e_jmp});
    compare_field("ex_branch", {31'd0, ex_branch}, {31'd0, e_br});
    compare_field("ex_load", {31'd0, ex_load}, {31'd0, e_ld});
    compare_field("ex_store", {31'd0, ex_store}, {31'd0, e_st});
    compare_field("ex_illegal", {31'd0, ex_illegal}, {31'd0, e_ill});
    compare_field("ex_valid", {31'd0, ex_valid}, {31'd0, e_valid});
  endtask

  initial begin
    seed        = 3087;
    errors      = 0;
    checks      = 0;
    CLK         = 1'b0;
    nRST        = 1'b0;
    instr.raw   = '0;
    pc          = '0;
    instr_valid = 1'b0;
    stall_ex    = 1'b0;
    flush       = 1'b0;
    wb_en       = 1'b0;
    wb_rd       = '0;
    wb_data     = '0;
    iflush_done = 1'b0;
    dflush_done = 1'b0;
    iflushed_m  = 1'b1;
    dflushed_m  = 1'b1;
    icount      = 0;
    dcount      = 0;
    hold_instr  = 1'b0;
    for (int i = 0; i < 32; i++)
      mregs[i] = '0;
    clear_expected();

    repeat (RESET_CYCLES) @(posedge CLK);
    #5;
    // latch must come out of reset empty
    check_outputs();
    #5;
    nRST = 1'b1;

    for (int c = 0; c < TEST_CYCLES; c++) begin
      @(posedge CLK);
      #5;
      check_outputs();
      #5;
      drive_inputs();
      #1;
      step_model();
    end

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD + 10 * CLK_PERIOD);
    $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
logic/decode_pkg.sv
logic/instr_decoder.sv
logic/imm_gen.sv
logic/reg_file.sv
logic/operand_select.sv
logic/fence_tracker.sv
logic/decode_execute_latch.sv
logic/rv_decode_stage.sv
test/decode_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the decode stage testbench, then look for the pass line in the log
rm -f sim.log
verilator --binary --timing --assert -f compile.f --top-module decode_tb -o decode_sim \
  && ./obj_dir/decode_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^TEST OK$" sim.log 2>/dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
